//--- include/merge_sort_macros.svh
// record widths, way count, fifo depth and end-of-stream sentinel key
`ifndef MERGE_SORT_MACROS_SVH
`define MERGE_SORT_MACROS_SVH

// record key, compared by every merge node
`define MERGE_SORT_KEY_W 32

// record payload, carried along untouched
`define MERGE_SORT_VAL_W 32

// log2 of way count, 4 ways with a 2-bit way tag
`define MERGE_SORT_WAY_LOG 2

// log2 of every fifo depth, 4 entries
`define MERGE_SORT_FIFO_LOG 2

// all-ones key closes a stream
`define MERGE_SORT_KEY_MAX 32'hFFFF_FFFF

`endif

//--- hdl/merge_sort_pkg.sv
// record and tagged input beat types for the merge sorter tree
`include "merge_sort_macros.svh"

package merge_sort_pkg;

  // one sortable record
  // key sits in the upper half so the whole word orders like the key
  typedef struct packed {
    logic [`MERGE_SORT_KEY_W-1:0] key;
    logic [`MERGE_SORT_VAL_W-1:0] value;
  } record_t;

  // input beat, record plus the way it belongs to
  typedef struct packed {
    logic [`MERGE_SORT_WAY_LOG-1:0] way;
    record_t                        rec;
  } in_beat_t;

endpackage

//--- hdl/record_fifo.sv
// circular record fifo with count-based empty/full and protocol assertions
`timescale 1ns/1ps
`include "merge_sort_macros.svh"

module record_fifo #(
  parameter int DEPTH_LOG = `MERGE_SORT_FIFO_LOG
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    i_enq,
  input  logic                    i_deq,
  input  merge_sort_pkg::record_t i_rec,
  output merge_sort_pkg::record_t o_head,
  output logic                    o_emp,
  output logic                    o_full
);
  import merge_sort_pkg::*;

  localparam int DEPTH = 2 ** DEPTH_LOG;
  // at least one pointer bit, even for a single entry
  localparam int PTR_W = (DEPTH_LOG > 0) ? DEPTH_LOG : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [DEPTH_LOG:0] FULL_CNT = (DEPTH_LOG + 1)'(DEPTH);

  record_t              mem [DEPTH];
  logic [PTR_W-1:0]     head_ptr;
  logic [PTR_W-1:0]     tail_ptr;
  logic [DEPTH_LOG:0]   count;

  // wrap at the last entry, depth need not fill the pointer
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // head is read combinationally, no read latency
  assign o_head = mem[head_ptr];
  assign o_emp  = (count == '0);
  assign o_full = (count == FULL_CNT);

  // storage
  always_ff @(posedge CLK) begin
    if (i_enq) begin
      mem[tail_ptr] <= i_rec;
    end
  end

  // pointers and occupancy
  always_ff @(posedge CLK) begin
    if (RST) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (i_enq) begin
        tail_ptr <= ptr_inc(tail_ptr);
      end
      if (i_deq) begin
        head_ptr <= ptr_inc(head_ptr);
      end
      // simultaneous enq and deq keep the count
      case ({i_enq, i_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // writer must respect full
  a_no_overflow: assert property (@(posedge CLK) disable iff (RST) i_enq |-> !o_full);
  // reader must respect empty
  a_no_underflow: assert property (@(posedge CLK) disable iff (RST) i_deq |-> !o_emp);

endmodule

//--- hdl/leaf_buffers.sv
// input side, way tag decode into four way fifos with heads, empties and fulls
`timescale 1ns/1ps
`include "merge_sort_macros.svh"

module leaf_buffers (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   i_in_valid,
  input  merge_sort_pkg::in_beat_t               i_in_beat,
  input  logic [(1 << `MERGE_SORT_WAY_LOG)-1:0]  i_deq,
  output wire merge_sort_pkg::record_t           o_heads [1 << `MERGE_SORT_WAY_LOG],
  output wire [(1 << `MERGE_SORT_WAY_LOG)-1:0]   o_emp,
  output wire [(1 << `MERGE_SORT_WAY_LOG)-1:0]   o_way_full
);
  import merge_sort_pkg::*;

  localparam int NUM_WAYS = 1 << `MERGE_SORT_WAY_LOG;

  logic [NUM_WAYS-1:0] way_enq;
  record_t             beat_rec;

  // payload goes to every fifo, only the tagged one writes
  assign beat_rec = i_in_beat.rec;

  // one-hot enqueue from the way tag
  always_comb begin
    way_enq = '0;
    way_enq[i_in_beat.way] = i_in_valid;
  end

  // one fifo per way
  // deq comes from the leaf merge node reading that way
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    record_fifo u_way_fifo (
      .CLK    (CLK),
      .RST    (RST),
      .i_enq  (way_enq[w]),
      .i_deq  (i_deq[w]),
      .i_rec  (beat_rec),
      .o_head (o_heads[w]),
      .o_emp  (o_emp[w]),
      .o_full (o_way_full[w])
    );
  end

  // producer must hold off while the tagged way is full
  a_way_free: assert property (
    @(posedge CLK) disable iff (RST)
    i_in_valid |-> !o_way_full[i_in_beat.way]
  );

endmodule

//--- hdl/merge_node.sv
// two-input merge node, dequeues the smaller head into its own output fifo
`timescale 1ns/1ps

module merge_node (
  input  logic                    CLK,
  input  logic                    RST,
  input  merge_sort_pkg::record_t i_head0,
  input  merge_sort_pkg::record_t i_head1,
  input  logic                    i_emp0,
  input  logic                    i_emp1,
  input  logic                    i_deq,
  output logic                    o_deq0,
  output logic                    o_deq1,
  output merge_sort_pkg::record_t o_head,
  output logic                    o_emp
);
  import merge_sort_pkg::*;

  logic    fire;
  logic    take0;
  logic    out_full;
  record_t win_rec;

  // both heads present and room downstream
  assign fire = !i_emp0 && !i_emp1 && !out_full;

  // strictly smaller key wins for input 0
  // on a tie input 1 moves on
  assign take0 = (i_head0.key < i_head1.key);

  assign o_deq0  = fire && take0;
  assign o_deq1  = fire && !take0;
  assign win_rec = take0 ? i_head0 : i_head1;

  // winner lands here at the same edge it leaves its source
  record_fifo u_out_fifo (
    .CLK    (CLK),
    .RST    (RST),
    .i_enq  (fire),
    .i_deq  (i_deq),
    .i_rec  (win_rec),
    .o_head (o_head),
    .o_emp  (o_emp),
    .o_full (out_full)
  );

  // one source per firing
  a_single_deq: assert property (
    @(posedge CLK) disable iff (RST)
    $onehot0({o_deq0, o_deq1})
  );

endmodule

//--- hdl/sorted_output.sv
// output side, pops the root head into a registered valid pulse under downstream full
`timescale 1ns/1ps

module sorted_output (
  input  logic                    CLK,
  input  logic                    RST,
  input  merge_sort_pkg::record_t i_head,
  input  logic                    i_emp,
  input  logic                    i_out_full,
  output logic                    o_deq,
  output merge_sort_pkg::record_t o_out_rec,
  output logic                    o_out_valid
);
  import merge_sort_pkg::*;

  // at least one record delivered since reset
  logic have_out;

  // pop whenever root has data and downstream has room
  assign o_deq = !i_emp && !i_out_full;

  // record register holds the last delivered record
  always_ff @(posedge CLK) begin
    if (o_deq) begin
      o_out_rec <= i_head;
    end
  end

  // one-cycle pulse per pop
  always_ff @(posedge CLK) begin
    if (RST) begin
      o_out_valid <= 1'b0;
      have_out    <= 1'b0;
    end else begin
      o_out_valid <= o_deq;
      if (o_deq) begin
        have_out <= 1'b1;
      end
    end
  end

  // the tree must never hand out a key below the one already delivered
  a_ascending: assert property (
    @(posedge CLK) disable iff (RST)
    (o_deq && have_out) |-> (i_head.key >= o_out_rec.key)
  );

endmodule

//--- hdl/merge_sort_tree.sv
// top level of the four-way merge sorter tree, input side, three merge nodes, output side
`timescale 1ns/1ps
`include "merge_sort_macros.svh"

module merge_sort_tree (
  input  logic                                   CLK,
  input  logic                                   RST,
  input  logic                                   i_in_valid,
  input  merge_sort_pkg::in_beat_t               i_in_beat,
  output wire [(1 << `MERGE_SORT_WAY_LOG)-1:0]   o_way_full,
  input  logic                                   i_out_full,
  output merge_sort_pkg::record_t                o_out_rec,
  output logic                                   o_out_valid
);
  import merge_sort_pkg::*;

  localparam int NUM_WAYS = 1 << `MERGE_SORT_WAY_LOG;

  // way heads from the input side
  wire record_t             way_head [NUM_WAYS];
  wire [NUM_WAYS-1:0]       way_emp;
  // way dequeues come back from two leaf nodes
  wire [NUM_WAYS-1:0]       way_deq;

  // leaf node outputs
  record_t a_head;
  logic    a_emp;
  logic    a_deq;
  record_t b_head;
  logic    b_emp;
  logic    b_deq;

  // root node output
  record_t root_head;
  logic    root_emp;
  logic    root_deq;

  leaf_buffers u_leaf_buffers (
    .CLK        (CLK),
    .RST        (RST),
    .i_in_valid (i_in_valid),
    .i_in_beat  (i_in_beat),
    .i_deq      (way_deq),
    .o_heads    (way_head),
    .o_emp      (way_emp),
    .o_way_full (o_way_full)
  );

  // ways 0 and 1
  merge_node node_a (
    .CLK     (CLK),
    .RST     (RST),
    .i_head0 (way_head[0]),
    .i_head1 (way_head[1]),
    .i_emp0  (way_emp[0]),
    .i_emp1  (way_emp[1]),
    .i_deq   (a_deq),
    .o_deq0  (way_deq[0]),
    .o_deq1  (way_deq[1]),
    .o_head  (a_head),
    .o_emp   (a_emp)
  );

  // ways 2 and 3
  merge_node node_b (
    .CLK     (CLK),
    .RST     (RST),
    .i_head0 (way_head[2]),
    .i_head1 (way_head[3]),
    .i_emp0  (way_emp[2]),
    .i_emp1  (way_emp[3]),
    .i_deq   (b_deq),
    .o_deq0  (way_deq[2]),
    .o_deq1  (way_deq[3]),
    .o_head  (b_head),
    .o_emp   (b_emp)
  );

  // root, node_b wins ties
  merge_node node_root (
    .CLK     (CLK),
    .RST     (RST),
    .i_head0 (a_head),
    .i_head1 (b_head),
    .i_emp0  (a_emp),
    .i_emp1  (b_emp),
    .i_deq   (root_deq),
    .o_deq0  (a_deq),
    .o_deq1  (b_deq),
    .o_head  (root_head),
    .o_emp   (root_emp)
  );

  sorted_output u_sorted_output (
    .CLK         (CLK),
    .RST         (RST),
    .i_head      (root_head),
    .i_emp       (root_emp),
    .i_out_full  (i_out_full),
    .o_deq       (root_deq),
    .o_out_rec   (o_out_rec),
    .o_out_valid (o_out_valid)
  );

endmodule

//--- tb/tb_merge_sort_tree.sv
// testbench for the four-way merge sorter tree, stimulus table, reference order and random stalls
`timescale 1ns/1ps
`include "merge_sort_macros.svh"

module tb_merge_sort_tree;
  import merge_sort_pkg::*;

  localparam int NUM_WAYS    = 1 << `MERGE_SORT_WAY_LOG;
  localparam int NUM_ENTRIES = 20;
  localparam int NUM_REAL    = 16;
  localparam int TIMEOUT_CYC = 400;

  logic                  CLK;
  logic                  RST;
  logic                  i_in_valid;
  in_beat_t              i_in_beat;
  logic                  i_out_full;
  logic [NUM_WAYS-1:0]   o_way_full;
  record_t               o_out_rec;
  logic                  o_out_valid;

  // stimulus table and the sorted reference built from it
  in_beat_t                     stim [NUM_ENTRIES];
  record_t                      exp_rec [NUM_REAL];
  logic [`MERGE_SORT_VAL_W-1:0] tail_val;
  int                           out_count;
  logic                         stall_en;
  logic                         full_prev = 1'b0;
  integer                       seed;

  merge_sort_tree uut (
    .CLK         (CLK),
    .RST         (RST),
    .i_in_valid  (i_in_valid),
    .i_in_beat   (i_in_beat),
    .o_way_full  (o_way_full),
    .i_out_full  (i_out_full),
    .o_out_rec   (o_out_rec),
    .o_out_valid (o_out_valid)
  );

  // 8 ns clock
  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic set_entry(input int idx, input logic [`MERGE_SORT_WAY_LOG-1:0] way,
                           input logic [31:0] key, input logic [31:0] value);
    stim[idx].way       = way;
    stim[idx].rec.key   = key;
    stim[idx].rec.value = value;
  endtask

  // way 0 first so it fills alone, sentinels last
  task automatic load_table();
    set_entry(0,  2'd0, 32'h0000_0010, 32'h1000_0000);
    set_entry(1,  2'd0, 32'h0000_0025, 32'h1000_0001);
    set_entry(2,  2'd0, 32'h0000_0040, 32'h1000_0002);
    set_entry(3,  2'd0, 32'h0000_0090, 32'h1000_0003);
    set_entry(4,  2'd1, 32'h0000_0005, 32'h2000_0000);
    set_entry(5,  2'd1, 32'h0000_0030, 32'h2000_0001);
    set_entry(6,  2'd1, 32'h0000_0041, 32'h2000_0002);
    set_entry(7,  2'd1, 32'h0000_0070, 32'h2000_0003);
    set_entry(8,  2'd2, 32'h0000_0012, 32'h3000_0000);
    set_entry(9,  2'd2, 32'h0000_0013, 32'h3000_0001);
    set_entry(10, 2'd2, 32'h0000_0060, 32'h3000_0002);
    set_entry(11, 2'd2, 32'h0000_00A0, 32'h3000_0003);
    set_entry(12, 2'd3, 32'h0000_0001, 32'h4000_0000);
    set_entry(13, 2'd3, 32'h0000_0050, 32'h4000_0001);
    set_entry(14, 2'd3, 32'h0000_0051, 32'h4000_0002);
    set_entry(15, 2'd3, 32'h0000_0052, 32'h4000_0003);
    set_entry(16, 2'd0, `MERGE_SORT_KEY_MAX, 32'h5E00_0000);
    set_entry(17, 2'd1, `MERGE_SORT_KEY_MAX, 32'h5E00_0001);
    set_entry(18, 2'd2, `MERGE_SORT_KEY_MAX, 32'h5E00_0002);
    set_entry(19, 2'd3, `MERGE_SORT_KEY_MAX, 32'h5E00_0003);
  endtask

  // insertion sort of the real records by key
  task automatic build_expected();
    int n;
    int j;
    n = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stim[i].rec.key != `MERGE_SORT_KEY_MAX) begin
        j = n;
        while (j > 0 && exp_rec[j-1].key > stim[i].rec.key) begin
          exp_rec[j] = exp_rec[j-1];
          j--;
        end
        exp_rec[j] = stim[i].rec;
        n++;
      end else if (stim[i].way == NUM_WAYS - 1) begin
        // ties pass the upper input at every level, so way 3's sentinel survives
        tail_val = stim[i].rec.value;
      end
    end
  endtask

  // one strobe once the target way has room
  task automatic apply_entry(input int idx);
    int waited;
    waited = 0;
    @(negedge CLK);
    while (o_way_full[stim[idx].way] && waited < TIMEOUT_CYC) begin
      @(negedge CLK);
      waited++;
    end
    assert (!o_way_full[stim[idx].way]) else
      stop_on_error($sformatf("timeout: way %0d stayed full for %0d cycles at %0t",
                              stim[idx].way, waited, $time));
    @(posedge CLK);
    i_in_valid <= 1'b1;
    i_in_beat  <= stim[idx];
    @(posedge CLK);
    i_in_valid <= 1'b0;
  endtask

  task automatic check_output(input record_t got);
    assert (out_count <= NUM_REAL) else
      stop_on_error($sformatf("an extra record came out after the sentinel at %0t", $time));
    if (out_count < NUM_REAL) begin
      assert (got.key == exp_rec[out_count].key) else
        stop_on_error($sformatf("Fail at %0t: o_out_rec.key got %h expected %h",
                                $time, got.key, exp_rec[out_count].key));
      assert (got.value == exp_rec[out_count].value) else
        stop_on_error($sformatf("Fail at %0t: o_out_rec.value got %h expected %h",
                                $time, got.value, exp_rec[out_count].value));
    end else begin
      assert (got.key == `MERGE_SORT_KEY_MAX) else
        stop_on_error($sformatf("Fail at %0t: o_out_rec.key got %h expected %h",
                                $time, got.key, `MERGE_SORT_KEY_MAX));
      assert (got.value == tail_val) else
        stop_on_error($sformatf("Fail at %0t: o_out_rec.value got %h expected %h",
                                $time, got.value, tail_val));
    end
    out_count++;
  endtask

  // output monitor at the falling edge, outputs are settled here
  always @(negedge CLK) begin
    if (!RST) begin
      // full at the last edge means no pulse now
      assert (!(o_out_valid && full_prev)) else
        stop_on_error($sformatf("Fail at %0t: o_out_valid got 1 expected 0", $time));
      if (o_out_valid) begin
        check_output(o_out_rec);
      end
    end
    // level that the next rising edge will see
    full_prev = i_out_full;
  end

  // random stall stretches on the downstream full level
  initial begin : stall_gen
    int run;
    seed       = 32'h2412;
    run        = 0;
    i_out_full <= 1'b0;
    forever begin
      @(posedge CLK);
      if (!stall_en) begin
        i_out_full <= 1'b0;
        run = 0;
      end else if (run == 0) begin
        i_out_full <= (($random(seed) & 32'h1) != 0);
        run = 1 + ($unsigned($random(seed)) % 6);
      end else begin
        run--;
      end
    end
  end

  initial begin
    int waited;
    RST        <= 1'b1;
    i_in_valid <= 1'b0;
    i_in_beat  <= '0;
    stall_en   = 1'b0;
    out_count  = 0;
    load_table();
    build_expected();
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    // quiet after reset
    repeat (8) begin
      @(negedge CLK);
      assert (!o_out_valid) else
        stop_on_error($sformatf("Fail at %0t: o_out_valid got %b expected 0",
                                $time, o_out_valid));
      assert (o_way_full == '0) else
        stop_on_error($sformatf("Fail at %0t: o_way_full got %b expected 0000",
                                $time, o_way_full));
    end

    // way 0 alone fills, no node fires with one head
    for (int i = 0; i < 4; i++) begin
      apply_entry(i);
    end
    @(negedge CLK);
    assert (o_way_full == 4'b0001) else
      stop_on_error($sformatf("Fail at %0t: o_way_full got %b expected 0001",
                              $time, o_way_full));
    repeat (10) @(negedge CLK);
    assert (out_count == 0) else
      stop_on_error($sformatf("Fail at %0t: output count got %0d expected 0",
                              $time, out_count));

    // rest of the table under random back-pressure
    stall_en = 1'b1;
    for (int i = 4; i < NUM_ENTRIES; i++) begin
      apply_entry(i);
    end
    waited = 0;
    while (out_count < NUM_REAL + 1 && waited < TIMEOUT_CYC) begin
      @(negedge CLK);
      waited++;
    end
    assert (out_count == NUM_REAL + 1) else
      stop_on_error($sformatf("timeout: only %0d of %0d records came out at %0t",
                              out_count, NUM_REAL + 1, $time));
    stall_en = 1'b0;

    // both leaves starve after one sentinel each, so nothing more
    repeat (20) begin
      @(negedge CLK);
      assert (!o_out_valid) else
        stop_on_error($sformatf("Fail at %0t: o_out_valid got %b expected 0",
                                $time, o_out_valid));
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
hdl/merge_sort_pkg.sv
hdl/record_fifo.sv
hdl/leaf_buffers.sv
hdl/merge_node.sv
hdl/sorted_output.sv
hdl/merge_sort_tree.sv
tb/tb_merge_sort_tree.sv
